//--- hw/eink_pkg.sv
package eink_pkg;

  // Panel geometry.
  localparam int FB_ROWS    = 250;
  localparam int FB_COLS    = 16;
  localparam int GLYPH_ROWS = 8;

  // Raw sensor limits for 0% and 100%.
  localparam logic [11:0] HUM_RAW_MIN = 12'h650;
  localparam logic [11:0] HUM_RAW_MAX = 12'hD40;

  // Field placement on the screen.
  localparam int HUM_ROW      = 130;
  localparam int HUM_MSD_COL  = 3;
  localparam int TEMP_ROW     = 117;
  localparam int TEMP_MSD_COL = 3;

  typedef logic [7:0]  fb_row_t;
  typedef logic [3:0]  fb_col_t;
  typedef logic [7:0]  fb_byte_t;
  typedef logic [11:0] hum_raw_t;
  typedef logic [7:0]  bcd2_t;
  typedef logic [11:0] bcd3_t;

  // 8x8 digit glyphs, bit 0 is the leftmost pixel.
  localparam fb_byte_t DIGIT_FONT [0:9][0:GLYPH_ROWS-1] = '{
    // 0
    '{8'h3C, 8'h66, 8'h76, 8'h6E, 8'h66, 8'h66, 8'h3C, 8'h00},
    // 1
    '{8'h18, 8'h1C, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
    // 2
    '{8'h3C, 8'h66, 8'h60, 8'h30, 8'h0C, 8'h06, 8'h7E, 8'h00},
    // 3
    '{8'h3C, 8'h66, 8'h60, 8'h38, 8'h60, 8'h66, 8'h3C, 8'h00},
    // 4
    '{8'h30, 8'h38, 8'h3C, 8'h36, 8'h7E, 8'h30, 8'h30, 8'h00},
    // 5
    '{8'h7E, 8'h06, 8'h3E, 8'h60, 8'h60, 8'h66, 8'h3C, 8'h00},
    // 6
    '{8'h3C, 8'h66, 8'h06, 8'h3E, 8'h66, 8'h66, 8'h3C, 8'h00},
    // 7
    '{8'h7E, 8'h66, 8'h60, 8'h30, 8'h18, 8'h18, 8'h18, 8'h00},
    // 8
    '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
    // 9
    '{8'h3C, 8'h66, 8'h66, 8'h7C, 8'h60, 8'h66, 8'h3C, 8'h00}
  };

endpackage

//--- hw/humidity_scaler.sv
`timescale 1ns/1ps

module humidity_scaler import eink_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  hum_raw_t hum_raw,
  output logic     busy,
  output logic     done,
  output bcd3_t    percent_bcd
);

  typedef enum logic [1:0] {S_IDLE, S_CLAMP, S_DIV, S_BCD} state_t;

  state_t      state;
  hum_raw_t    raw_q;
  logic [10:0] diff;
  logic [17:0] rem;
  logic [17:0] div_term;
  logic [18:0] trial;
  logic [7:0]  quotient;
  logic [2:0]  bit_cnt;
  logic [7:0]  low_part;

  // Offset from the lower limit, clamped to the span.
  always_comb begin
    if (raw_q <= HUM_RAW_MIN) begin
      diff = '0;
    end else if (raw_q >= HUM_RAW_MAX) begin
      diff = 11'(HUM_RAW_MAX - HUM_RAW_MIN);
    end else begin
      diff = 11'(raw_q - HUM_RAW_MIN);
    end
  end

  // Trial subtraction of the span aligned to the current quotient bit.
  assign div_term = 18'(HUM_RAW_MAX - HUM_RAW_MIN) << bit_cnt;
  assign trial    = {1'b0, rem} - {1'b0, div_term};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (start) state <= S_CLAMP;
        S_CLAMP: state <= S_DIV;
        S_DIV:   if (bit_cnt == 3'd0) state <= S_BCD;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      raw_q <= hum_raw;
    end
    if (state == S_CLAMP) begin
      rem      <= 18'(diff) * 18'd100;
      quotient <= '0;
      bit_cnt  <= 3'd7;
    end else if (state == S_DIV) begin
      if (!trial[18]) begin
        rem      <= trial[17:0];
        quotient <= {quotient[6:0], 1'b1};
      end else begin
        quotient <= {quotient[6:0], 1'b0};
      end
      bit_cnt <= bit_cnt - 3'd1;
    end
  end

  assign busy = (state != S_IDLE);
  assign done = (state == S_BCD);

  // Quotient never exceeds 100.
  assign low_part    = (quotient >= 8'd100) ? quotient - 8'd100 : quotient;
  assign percent_bcd = {(quotient >= 8'd100) ? 4'd1 : 4'd0,
                        4'(low_part / 8'd10),
                        4'(low_part % 8'd10)};

endmodule

//--- hw/digit_painter.sv
`timescale 1ns/1ps

module digit_painter import eink_pkg::*; #(
  parameter type digits_t  = bcd2_t,
  parameter int  FIELD_ROW = 0,
  parameter int  MSD_COL   = 0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  digits_t  digits,
  output logic     busy,
  output logic     wr_req,
  output fb_row_t  wr_row,
  output fb_col_t  wr_col,
  output fb_byte_t wr_data,
  input  logic     wr_gnt
);

  localparam int NUM_DIGITS = $bits(digits_t) / 4;

  digits_t    digits_q;
  logic [1:0] digit_idx;
  logic [2:0] glyph_row;
  logic [3:0] nibble;
  logic       last_row;
  logic       last_digit;

  // Digit 0 is the most significant nibble.
  assign nibble = 4'(digits_q >> (4 * (NUM_DIGITS - 1 - int'(digit_idx))));

  assign last_row   = (glyph_row == 3'(GLYPH_ROWS - 1));
  assign last_digit = (digit_idx == 2'(NUM_DIGITS - 1));

  // Request stays up with a fixed address until granted.
  assign wr_req  = busy;
  assign wr_row  = fb_row_t'(FIELD_ROW) + fb_row_t'(glyph_row);
  assign wr_col  = fb_col_t'(MSD_COL) - fb_col_t'(digit_idx);
  assign wr_data = (nibble <= 4'd9) ? DIGIT_FONT[nibble][glyph_row] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      digit_idx <= '0;
      glyph_row <= '0;
    end else if (!busy) begin
      if (start) begin
        busy      <= 1'b1;
        digit_idx <= '0;
        glyph_row <= '0;
      end
    end else if (wr_gnt) begin
      if (last_row) begin
        glyph_row <= '0;
        if (last_digit) begin
          busy <= 1'b0;
        end else begin
          digit_idx <= digit_idx + 2'd1;
        end
      end else begin
        glyph_row <= glyph_row + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      digits_q <= digits;
    end
  end

endmodule

//--- hw/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import eink_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     a_req,
  input  fb_row_t  a_row,
  input  fb_col_t  a_col,
  input  fb_byte_t a_data,
  output logic     a_gnt,
  input  logic     b_req,
  input  fb_row_t  b_row,
  input  fb_col_t  b_col,
  input  fb_byte_t b_data,
  output logic     b_gnt,
  input  fb_row_t  rd_row,
  input  fb_col_t  rd_col,
  output fb_byte_t rd_data
);

  fb_byte_t mem [0:FB_ROWS-1][0:FB_COLS-1];

  logic     last_b;
  logic     wr_en;
  fb_row_t  wr_row;
  fb_col_t  wr_col;
  fb_byte_t wr_data;

  // Round robin, the last winner yields on a tie.
  assign a_gnt = a_req && (!b_req || last_b);
  assign b_gnt = b_req && (!a_req || !last_b);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_b <= 1'b0;
    end else if (a_gnt) begin
      last_b <= 1'b0;
    end else if (b_gnt) begin
      last_b <= 1'b1;
    end
  end

  assign wr_en   = a_gnt || b_gnt;
  assign wr_row  = a_gnt ? a_row : b_row;
  assign wr_col  = a_gnt ? a_col : b_col;
  assign wr_data = a_gnt ? a_data : b_data;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row][wr_col] <= wr_data;
    end
  end

  // Panel driver read port, one cycle latency.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_row][rd_col];
  end

endmodule

//--- hw/eink_frame_top.sv
`timescale 1ns/1ps

module eink_frame_top import eink_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     update,
  input  bcd2_t    temperature_bcd,
  input  hum_raw_t humidity_raw,
  input  fb_row_t  rd_row,
  input  fb_col_t  rd_col,
  output fb_byte_t rd_data,
  output logic     busy
);

  logic     scaler_busy;
  logic     scaler_done;
  bcd3_t    percent_bcd;
  logic     temp_busy;
  logic     hum_busy;

  logic     a_req;
  logic     a_gnt;
  fb_row_t  a_row;
  fb_col_t  a_col;
  fb_byte_t a_data;
  logic     b_req;
  logic     b_gnt;
  fb_row_t  b_row;
  fb_col_t  b_col;
  fb_byte_t b_data;

  humidity_scaler u_scaler (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (update),
    .hum_raw     (humidity_raw),
    .busy        (scaler_busy),
    .done        (scaler_done),
    .percent_bcd (percent_bcd)
  );

  digit_painter #(
    .digits_t  (bcd2_t),
    .FIELD_ROW (TEMP_ROW),
    .MSD_COL   (TEMP_MSD_COL)
  ) u_temp_painter (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (update),
    .digits  (temperature_bcd),
    .busy    (temp_busy),
    .wr_req  (a_req),
    .wr_row  (a_row),
    .wr_col  (a_col),
    .wr_data (a_data),
    .wr_gnt  (a_gnt)
  );

  // Humidity field starts once the percent is ready.
  digit_painter #(
    .digits_t  (bcd3_t),
    .FIELD_ROW (HUM_ROW),
    .MSD_COL   (HUM_MSD_COL)
  ) u_hum_painter (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (scaler_done),
    .digits  (percent_bcd),
    .busy    (hum_busy),
    .wr_req  (b_req),
    .wr_row  (b_row),
    .wr_col  (b_col),
    .wr_data (b_data),
    .wr_gnt  (b_gnt)
  );

  frame_buffer u_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .a_req   (a_req),
    .a_row   (a_row),
    .a_col   (a_col),
    .a_data  (a_data),
    .a_gnt   (a_gnt),
    .b_req   (b_req),
    .b_row   (b_row),
    .b_col   (b_col),
    .b_data  (b_data),
    .b_gnt   (b_gnt),
    .rd_row  (rd_row),
    .rd_col  (rd_col),
    .rd_data (rd_data)
  );

  assign busy = scaler_busy || temp_busy || hum_busy;

endmodule

//--- tb/eink_frame_assert.sv
`timescale 1ns/1ps

module eink_frame_assert import eink_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     a_req,
  input fb_row_t  a_row,
  input fb_col_t  a_col,
  input fb_byte_t a_data,
  input logic     a_gnt,
  input logic     b_req,
  input fb_row_t  b_row,
  input fb_col_t  b_col,
  input fb_byte_t b_data,
  input logic     b_gnt
);

  // One writer per cycle.
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(a_gnt && b_gnt)) else $error("both write ports granted in one cycle");

  a_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    a_gnt |-> a_req) else $error("port a granted without a request");

  b_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    b_gnt |-> b_req) else $error("port b granted without a request");

  // Waiting writer holds its request, address and data.
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (a_req && !a_gnt) |=> (a_req && $stable(a_row) && $stable(a_col) && $stable(a_data)))
    else $error("port a request changed while waiting");

  b_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (b_req && !b_gnt) |=> (b_req && $stable(b_row) && $stable(b_col) && $stable(b_data)))
    else $error("port b request changed while waiting");

endmodule

bind frame_buffer eink_frame_assert u_assert (
  .clk    (clk),
  .rst_n  (rst_n),
  .a_req  (a_req),
  .a_row  (a_row),
  .a_col  (a_col),
  .a_data (a_data),
  .a_gnt  (a_gnt),
  .b_req  (b_req),
  .b_row  (b_row),
  .b_col  (b_col),
  .b_data (b_data),
  .b_gnt  (b_gnt)
);

//--- tb/tb_eink_frame.sv
`timescale 1ns/1ps

module tb_eink_frame import eink_pkg::*; ();

  localparam int NUM_HAND   = 8;
  localparam int NUM_RAND   = 4;
  localparam int NUM_TESTS  = NUM_HAND + NUM_RAND;
  localparam int WAIT_LIMIT = 400;

  // Hand-written entries: raw reading, temperature, floor percent.
  localparam logic [11:0] HAND_RAW [0:NUM_HAND-1] = '{
    12'h000, 12'h650, 12'hD40, 12'hFFF, 12'h9C8, 12'h651, 12'hD3F, 12'h7A0
  };
  localparam logic [7:0] HAND_TEMP [0:NUM_HAND-1] = '{
    8'h25, 8'h99, 8'h07, 8'h40, 8'hA3, 8'h18, 8'h31, 8'h5B
  };
  localparam int HAND_PCT [0:NUM_HAND-1] = '{0, 0, 100, 100, 50, 0, 99, 18};

  logic     clk;
  logic     rst_n;
  logic     update;
  bcd2_t    temperature_bcd;
  hum_raw_t humidity_raw;
  fb_row_t  rd_row;
  fb_col_t  rd_col;
  fb_byte_t rd_data;
  logic     busy;

  hum_raw_t raw_tab  [0:NUM_TESTS-1];
  bcd2_t    temp_tab [0:NUM_TESTS-1];
  int       pct_tab  [0:NUM_TESTS-1];

  int total_errs;
  int test_errs;
  int checks;

  eink_frame_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .update          (update),
    .temperature_bcd (temperature_bcd),
    .humidity_raw    (humidity_raw),
    .rd_row          (rd_row),
    .rd_col          (rd_col),
    .rd_data         (rd_data),
    .busy            (busy)
  );

  always #2 clk = ~clk;

  // Floor percent with clamping at both limits.
  function automatic int floor_percent(input int raw);
    if (raw <= int'(HUM_RAW_MIN)) begin
      return 0;
    end else if (raw >= int'(HUM_RAW_MAX)) begin
      return 100;
    end
    return ((raw - int'(HUM_RAW_MIN)) * 100) / (int'(HUM_RAW_MAX) - int'(HUM_RAW_MIN));
  endfunction

  task automatic read_byte(input int row, input int col, output fb_byte_t data);
    @(negedge clk);
    rd_row = fb_row_t'(row);
    rd_col = fb_col_t'(col);
    @(negedge clk);
    data = rd_data;
  endtask

  task automatic check_glyph(input int row0, input int col, input logic [3:0] nib);
    fb_byte_t got;
    fb_byte_t want;
    int       r;
    for (r = 0; r < GLYPH_ROWS; r++) begin
      want = (nib <= 4'd9) ? DIGIT_FONT[nib][r] : 8'h00;
      read_byte(row0 + r, col, got);
      checks++;
      if (got !== want) begin
        $display("CHECK FAILED rd_data row %0d col %0d: got %h expected %h",
                 row0 + r, col, got, want);
        test_errs++;
      end
    end
  endtask

  task automatic run_update(input int idx);
    int cycles;
    @(negedge clk);
    humidity_raw    = raw_tab[idx];
    temperature_bcd = temp_tab[idx];
    update          = 1'b1;
    @(negedge clk);
    update = 1'b0;
    if (busy !== 1'b1) begin
      $display("CHECK FAILED busy after update: got %h expected 1", busy);
      test_errs++;
    end
    cycles = 0;
    while (busy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("Test %0d: busy did not fall within %0d cycles", idx, WAIT_LIMIT);
      test_errs++;
    end
  endtask

  initial begin
    void'($urandom(47));
    clk             = 1'b0;
    rst_n           = 1'b0;
    update          = 1'b0;
    temperature_bcd = '0;
    humidity_raw    = '0;
    rd_row          = '0;
    rd_col          = '0;
    total_errs      = 0;
    checks          = 0;

    for (int i = 0; i < NUM_HAND; i++) begin
      raw_tab[i]  = HAND_RAW[i];
      temp_tab[i] = HAND_TEMP[i];
      pct_tab[i]  = HAND_PCT[i];
    end
    for (int i = NUM_HAND; i < NUM_TESTS; i++) begin
      raw_tab[i]  = hum_raw_t'($urandom % 4096);
      temp_tab[i] = {4'($urandom % 10), 4'($urandom % 10)};
      pct_tab[i]  = floor_percent(int'(raw_tab[i]));
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset.
    repeat (4) begin
      @(negedge clk);
      checks++;
      if (busy !== 1'b0) begin
        $display("CHECK FAILED busy after reset: got %h expected 0", busy);
        total_errs++;
      end
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errs = 0;
      run_update(t);
      check_glyph(TEMP_ROW, TEMP_MSD_COL, temp_tab[t][7:4]);
      check_glyph(TEMP_ROW, TEMP_MSD_COL - 1, temp_tab[t][3:0]);
      check_glyph(HUM_ROW, HUM_MSD_COL, 4'(pct_tab[t] / 100));
      check_glyph(HUM_ROW, HUM_MSD_COL - 1, 4'((pct_tab[t] / 10) % 10));
      check_glyph(HUM_ROW, HUM_MSD_COL - 2, 4'(pct_tab[t] % 10));
      $display("test %0d raw=%h temp=%h percent=%0d: %s (%0d errors)", t, raw_tab[t],
               temp_tab[t], pct_tab[t], (test_errs == 0) ? "ok" : "mismatch", test_errs);
      total_errs += test_errs;
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, total_errs);
    if (total_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (NUM_TESTS * WAIT_LIMIT) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
hw/eink_pkg.sv
hw/humidity_scaler.sv
hw/digit_painter.sv
hw/frame_buffer.sv
hw/eink_frame_top.sv
tb/eink_frame_assert.sv
tb/tb_eink_frame.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the frame testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_eink_frame

./obj_dir/Vtb_eink_frame > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
